// File: common/syscfg_pkg.sv
// ============================
// Shared definitions for the system configuration block
// Holds the address map, register offsets, widths and the
// partition controller state encoding, imported by every RTL file
// ============================

package syscfg_pkg;

  // ============================
  // Bus geometry
  // ============================
  localparam int unsigned SYSCFG_ADDR_W     = 16;
  localparam int unsigned SYSCFG_DATA_W     = 32;
  localparam int unsigned SYSCFG_STRB_W     = 4;
  // Region select lives in address bits 15:12
  localparam int unsigned SYSCFG_REGION_LSB = 12;
  localparam int unsigned SYSCFG_NB_SUB     = 3;

  localparam int unsigned BOOT_MODE_W       = 3;
  // Cycles between the clock edge and the reset edge of the NoC partition
  localparam int unsigned PCTL_SEQ_CYCLES   = 4;

  typedef logic [SYSCFG_ADDR_W-1:0]         syscfg_addr_t;
  typedef logic [SYSCFG_DATA_W-1:0]         syscfg_data_t;
  typedef logic [SYSCFG_STRB_W-1:0]         syscfg_strb_t;
  typedef logic [$clog2(SYSCFG_NB_SUB)-1:0] syscfg_sub_idx_t;
  typedef logic [BOOT_MODE_W-1:0]           boot_mode_t;
  typedef logic [$clog2(PCTL_SEQ_CYCLES):0] pctl_seq_cnt_t;

  // ============================
  // Address map
  // ============================
  // Slot index equals the region value, regions 3 to 15 are unmapped
  localparam syscfg_sub_idx_t SUB_IDX_MISC = 2'd0;
  localparam syscfg_sub_idx_t SUB_IDX_PCTL = 2'd1;
  localparam syscfg_sub_idx_t SUB_IDX_RSVD = 2'd2;

  // Misc CSR block
  localparam logic [SYSCFG_REGION_LSB-1:0] MISC_SCRATCH0_OFS    = 12'h000;
  localparam logic [SYSCFG_REGION_LSB-1:0] MISC_SCRATCH1_OFS    = 12'h004;
  localparam logic [SYSCFG_REGION_LSB-1:0] MISC_BOOT_MODE_OFS   = 12'h008;
  localparam logic [SYSCFG_REGION_LSB-1:0] MISC_GLOBAL_SYNC_OFS = 12'h00C;

  // NoC partition controller
  localparam logic [SYSCFG_REGION_LSB-1:0] PCTL_CTRL_OFS   = 12'h000;
  localparam logic [SYSCFG_REGION_LSB-1:0] PCTL_STATUS_OFS = 12'h004;

  // Partition sequencer states, readable in STATUS[1:0]
  typedef enum logic [1:0] {
    PCTL_OFF    = 2'd0,
    PCTL_CLK_ON = 2'd1,
    PCTL_ACTIVE = 2'd2,
    PCTL_RST_ON = 2'd3
  } pctl_state_e;

endpackage

// File: src/syscfg_apb_decode.sv
// ============================
// APB address decoder for the system configuration port
// Turns the region bits into a subordinate slot index,
// or flags the request as unmapped
// ============================

`timescale 1ns/10ps

module syscfg_apb_decode
  import syscfg_pkg::*;
(
  input  syscfg_addr_t    i_paddr,
  output syscfg_sub_idx_t o_sub_idx,
  output logic            o_unmapped
);

  localparam int unsigned REGION_W = SYSCFG_ADDR_W - SYSCFG_REGION_LSB;

  logic [REGION_W-1:0] region;

  always_comb region = i_paddr[SYSCFG_ADDR_W-1:SYSCFG_REGION_LSB];

  always_comb begin
    o_sub_idx  = SUB_IDX_RSVD;
    o_unmapped = 1'b0;
    case (region)
      REGION_W'(SUB_IDX_MISC): o_sub_idx = SUB_IDX_MISC;
      REGION_W'(SUB_IDX_PCTL): o_sub_idx = SUB_IDX_PCTL;
      REGION_W'(SUB_IDX_RSVD): o_sub_idx = SUB_IDX_RSVD;
      // Anything past the last slot has no owner
      default: begin
        o_sub_idx  = SUB_IDX_RSVD;
        o_unmapped = 1'b1;
      end
    endcase
  end

endmodule

// File: src/syscfg_apb_router.sv
// ============================
// APB router between the outside port and the subordinates
// Selects one subordinate from the decoded slot and merges its
// response, the reserved slot and unmapped space answer with an error
// ============================

`timescale 1ns/10ps

module syscfg_apb_router
  import syscfg_pkg::*;
(
  input  wire                              i_ref_clk,
  input  logic                             i_rst_n,

  // Upstream APB request
  input  logic                             i_psel,
  input  logic                             i_penable,
  input  logic                             i_pwrite,
  input  syscfg_addr_t                     i_paddr,
  input  syscfg_data_t                     i_pwdata,
  input  syscfg_strb_t                     i_pstrb,
  // From the decoder
  input  syscfg_sub_idx_t                  i_sub_idx,
  input  logic                             i_unmapped,

  // Upstream APB response
  output logic                             o_pready,
  output syscfg_data_t                     o_prdata,
  output logic                             o_pslverr,

  // Shared request toward the subordinates
  output logic                             o_misc_psel,
  output logic                             o_pctl_psel,
  output logic                             o_sub_penable,
  output logic                             o_sub_pwrite,
  output logic [SYSCFG_REGION_LSB-1:0]     o_sub_offset,
  output syscfg_data_t                     o_sub_pwdata,
  output syscfg_strb_t                     o_sub_pstrb,

  // Subordinate responses
  input  logic                             i_misc_pready,
  input  syscfg_data_t                     i_misc_prdata,
  input  logic                             i_misc_pslverr,
  input  logic                             i_pctl_pready,
  input  syscfg_data_t                     i_pctl_prdata,
  input  logic                             i_pctl_pslverr
);

  // Address, data and control fan out to every subordinate
  always_comb begin
    o_sub_penable = i_penable;
    o_sub_pwrite  = i_pwrite;
    o_sub_offset  = i_paddr[SYSCFG_REGION_LSB-1:0];
    o_sub_pwdata  = i_pwdata;
    o_sub_pstrb   = i_pstrb;
  end

  always_comb begin
    // Default answer covers the reserved slot and unmapped space
    o_misc_psel = 1'b0;
    o_pctl_psel = 1'b0;
    o_pready    = 1'b1;
    o_prdata    = '0;
    o_pslverr   = 1'b1;
    if (!i_unmapped) begin
      case (i_sub_idx)
        SUB_IDX_MISC: begin
          o_misc_psel = i_psel;
          o_pready    = i_misc_pready;
          o_prdata    = i_misc_prdata;
          o_pslverr   = i_misc_pslverr;
        end
        SUB_IDX_PCTL: begin
          o_pctl_psel = i_psel;
          o_pready    = i_pctl_pready;
          o_prdata    = i_pctl_prdata;
          o_pslverr   = i_pctl_pslverr;
        end
        default: begin
        end
      endcase
    end
  end

  // ============================
  // Protocol checks
  // ============================
  a_one_sub_selected: assert property (@(posedge i_ref_clk) disable iff (!i_rst_n)
    $onehot0({o_misc_psel, o_pctl_psel}))
    else $error("more than one subordinate selected");

  a_penable_needs_psel: assert property (@(posedge i_ref_clk) disable iff (!i_rst_n)
    i_penable |-> i_psel)
    else $error("penable high without psel");

endmodule

// File: src/syscfg_misc_csr.sv
// ============================
// Miscellaneous CSR block of the system configuration space
// Two scratch registers, boot-mode readback and the register
// that fires the one-cycle global sync pulse
// ============================

`timescale 1ns/10ps

module syscfg_misc_csr
  import syscfg_pkg::*;
(
  input  wire                              i_ref_clk,
  input  logic                             i_rst_n,
  input  logic                             i_psel,
  input  logic                             i_penable,
  input  logic                             i_pwrite,
  input  logic [SYSCFG_REGION_LSB-1:0]     i_offset,
  input  syscfg_data_t                     i_pwdata,
  input  syscfg_strb_t                     i_pstrb,
  input  boot_mode_t                       i_boot_mode,
  output logic                             o_pready,
  output syscfg_data_t                     o_prdata,
  output logic                             o_pslverr,
  output logic                             o_global_sync
);

  syscfg_data_t scratch0_q;
  syscfg_data_t scratch1_q;
  syscfg_data_t rdata;
  logic         acc_err;
  logic         wr_en;
  logic         global_sync_q;

  // Byte lanes with a set strobe take the new data
  function automatic syscfg_data_t merge_bytes(syscfg_data_t old_val,
                                               syscfg_data_t new_val,
                                               syscfg_strb_t strb);
    syscfg_data_t res;
    res = old_val;
    for (int b = 0; b < SYSCFG_STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Register decode
  always_comb begin
    rdata   = '0;
    acc_err = 1'b0;
    case (i_offset)
      MISC_SCRATCH0_OFS:    rdata = scratch0_q;
      MISC_SCRATCH1_OFS:    rdata = scratch1_q;
      MISC_BOOT_MODE_OFS: begin
        rdata   = syscfg_data_t'(i_boot_mode);
        acc_err = i_pwrite;
      end
      MISC_GLOBAL_SYNC_OFS: rdata = '0;
      default:              acc_err = 1'b1;
    endcase
  end

  // Zero wait states, failed reads return 0
  always_comb begin
    o_pready  = 1'b1;
    o_pslverr = acc_err;
    o_prdata  = acc_err ? '0 : rdata;
    wr_en     = i_psel & i_penable & i_pwrite & ~acc_err;
  end

  always_ff @(posedge i_ref_clk) begin
    if (!i_rst_n) begin
      scratch0_q    <= '0;
      scratch1_q    <= '0;
      global_sync_q <= 1'b0;
    end else begin
      if (wr_en && (i_offset == MISC_SCRATCH0_OFS)) begin
        scratch0_q <= merge_bytes(scratch0_q, i_pwdata, i_pstrb);
      end
      if (wr_en && (i_offset == MISC_SCRATCH1_OFS)) begin
        scratch1_q <= merge_bytes(scratch1_q, i_pwdata, i_pstrb);
      end
      // Pulse for the single cycle after the access edge
      global_sync_q <= wr_en && (i_offset == MISC_GLOBAL_SYNC_OFS);
    end
  end

  always_comb o_global_sync = global_sync_q;

  a_sync_single_cycle: assert property (@(posedge i_ref_clk) disable iff (!i_rst_n)
    o_global_sync |=> !o_global_sync)
    else $error("global sync pulse wider than one cycle");

endmodule

// File: noc_pctl/noc_pctl.sv
// ============================
// NoC partition controller
// CTRL bit 0 requests the partition on, the sequencer then
// orders clock enable and reset release, STATUS shows progress
// ============================

`timescale 1ns/10ps

module noc_pctl
  import syscfg_pkg::*;
(
  input  wire                              i_ref_clk,
  input  logic                             i_rst_n,
  input  logic                             i_psel,
  input  logic                             i_penable,
  input  logic                             i_pwrite,
  input  logic [SYSCFG_REGION_LSB-1:0]     i_offset,
  input  syscfg_data_t                     i_pwdata,
  input  syscfg_strb_t                     i_pstrb,
  output logic                             o_pready,
  output syscfg_data_t                     o_prdata,
  output logic                             o_pslverr,
  output logic                             o_noc_clk_en,
  output logic                             o_noc_rst_n
);

  localparam pctl_seq_cnt_t SEQ_LAST = pctl_seq_cnt_t'(PCTL_SEQ_CYCLES - 1);

  pctl_state_e   state_q;
  pctl_seq_cnt_t seq_cnt_q;
  logic          seq_done;
  logic          ctrl_q;
  logic          ctrl_d;
  logic          ctrl_wr;
  logic          clk_en_q;
  logic          rst_n_q;
  logic          acc_err;
  syscfg_data_t  rdata;

  // ============================
  // Register access
  // ============================
  always_comb begin
    rdata   = '0;
    acc_err = 1'b0;
    case (i_offset)
      PCTL_CTRL_OFS: rdata[0] = ctrl_q;
      PCTL_STATUS_OFS: begin
        rdata[1:0] = state_q;
        rdata[4]   = clk_en_q;
        rdata[5]   = rst_n_q;
        acc_err    = i_pwrite;
      end
      default: acc_err = 1'b1;
    endcase
  end

  always_comb begin
    o_pready  = 1'b1;
    o_pslverr = acc_err;
    o_prdata  = acc_err ? '0 : rdata;
    ctrl_wr   = i_psel & i_penable & i_pwrite & ~acc_err & i_pstrb[0]
                & (i_offset == PCTL_CTRL_OFS);
    // Request as seen after this edge, so OFF reacts at the write edge itself
    ctrl_d    = ctrl_wr ? i_pwdata[0] : ctrl_q;
    seq_done  = (seq_cnt_q == SEQ_LAST);
  end

  // ============================
  // Clock and reset sequencer
  // ============================
  always_ff @(posedge i_ref_clk) begin
    if (!i_rst_n) begin
      state_q   <= PCTL_OFF;
      seq_cnt_q <= '0;
      ctrl_q    <= 1'b0;
      clk_en_q  <= 1'b0;
      rst_n_q   <= 1'b0;
    end else begin
      ctrl_q <= ctrl_d;
      case (state_q)
        PCTL_OFF: begin
          if (ctrl_d) begin
            state_q   <= PCTL_CLK_ON;
            clk_en_q  <= 1'b1;
            seq_cnt_q <= '0;
          end
        end
        // Clock runs for a while before reset lets go
        PCTL_CLK_ON: begin
          if (seq_done) begin
            state_q <= PCTL_ACTIVE;
            rst_n_q <= 1'b1;
          end else begin
            seq_cnt_q <= seq_cnt_q + 1'b1;
          end
        end
        PCTL_ACTIVE: begin
          if (!ctrl_d) begin
            state_q   <= PCTL_RST_ON;
            rst_n_q   <= 1'b0;
            seq_cnt_q <= '0;
          end
        end
        // Reset held before the clock is gated
        PCTL_RST_ON: begin
          if (seq_done) begin
            state_q  <= PCTL_OFF;
            clk_en_q <= 1'b0;
          end else begin
            seq_cnt_q <= seq_cnt_q + 1'b1;
          end
        end
        default: state_q <= PCTL_OFF;
      endcase
    end
  end

  always_comb begin
    o_noc_clk_en = clk_en_q;
    o_noc_rst_n  = rst_n_q;
  end

  a_rst_inside_clk: assert property (@(posedge i_ref_clk) disable iff (!i_rst_n)
    o_noc_rst_n |-> o_noc_clk_en)
    else $error("NoC reset released while its clock is gated");

endmodule

// File: src/syscfg_mgmt_top.sv
// ============================
// Top level of the system configuration block
// One APB port in, decoder and router in front of the misc CSR
// block and the NoC partition controller
// ============================

`timescale 1ns/10ps

module syscfg_mgmt_top
  import syscfg_pkg::*;
(
  input  wire                              i_ref_clk,
  input  logic                             i_rst_n,

  // APB subordinate port
  input  syscfg_addr_t                     i_paddr,
  input  syscfg_data_t                     i_pwdata,
  input  logic                             i_pwrite,
  input  logic                             i_psel,
  input  logic                             i_penable,
  input  syscfg_strb_t                     i_pstrb,
  output logic                             o_pready,
  output syscfg_data_t                     o_prdata,
  output logic                             o_pslverr,

  input  boot_mode_t                       i_boot_mode,
  output logic                             o_global_sync,
  output logic                             o_noc_clk_en,
  output logic                             o_noc_rst_n
);

  syscfg_sub_idx_t                  sub_idx;
  logic                             unmapped;
  logic                             misc_psel;
  logic                             pctl_psel;
  logic                             sub_penable;
  logic                             sub_pwrite;
  logic [SYSCFG_REGION_LSB-1:0]     sub_offset;
  syscfg_data_t                     sub_pwdata;
  syscfg_strb_t                     sub_pstrb;
  logic                             misc_pready;
  syscfg_data_t                     misc_prdata;
  logic                             misc_pslverr;
  logic                             pctl_pready;
  syscfg_data_t                     pctl_prdata;
  logic                             pctl_pslverr;

  syscfg_apb_decode u_apb_decode (
    .i_paddr    ( i_paddr  ),
    .o_sub_idx  ( sub_idx  ),
    .o_unmapped ( unmapped )
  );

  syscfg_apb_router u_apb_router (
    .i_ref_clk      ( i_ref_clk    ),
    .i_rst_n        ( i_rst_n      ),
    .i_psel         ( i_psel       ),
    .i_penable      ( i_penable    ),
    .i_pwrite       ( i_pwrite     ),
    .i_paddr        ( i_paddr      ),
    .i_pwdata       ( i_pwdata     ),
    .i_pstrb        ( i_pstrb      ),
    .i_sub_idx      ( sub_idx      ),
    .i_unmapped     ( unmapped     ),
    .o_pready       ( o_pready     ),
    .o_prdata       ( o_prdata     ),
    .o_pslverr      ( o_pslverr    ),
    .o_misc_psel    ( misc_psel    ),
    .o_pctl_psel    ( pctl_psel    ),
    .o_sub_penable  ( sub_penable  ),
    .o_sub_pwrite   ( sub_pwrite   ),
    .o_sub_offset   ( sub_offset   ),
    .o_sub_pwdata   ( sub_pwdata   ),
    .o_sub_pstrb    ( sub_pstrb    ),
    .i_misc_pready  ( misc_pready  ),
    .i_misc_prdata  ( misc_prdata  ),
    .i_misc_pslverr ( misc_pslverr ),
    .i_pctl_pready  ( pctl_pready  ),
    .i_pctl_prdata  ( pctl_prdata  ),
    .i_pctl_pslverr ( pctl_pslverr )
  );

  syscfg_misc_csr u_misc_csr (
    .i_ref_clk     ( i_ref_clk     ),
    .i_rst_n       ( i_rst_n       ),
    .i_psel        ( misc_psel     ),
    .i_penable     ( sub_penable   ),
    .i_pwrite      ( sub_pwrite    ),
    .i_offset      ( sub_offset    ),
    .i_pwdata      ( sub_pwdata    ),
    .i_pstrb       ( sub_pstrb     ),
    .i_boot_mode   ( i_boot_mode   ),
    .o_pready      ( misc_pready   ),
    .o_prdata      ( misc_prdata   ),
    .o_pslverr     ( misc_pslverr  ),
    .o_global_sync ( o_global_sync )
  );

  noc_pctl u_noc_pctl (
    .i_ref_clk    ( i_ref_clk    ),
    .i_rst_n      ( i_rst_n      ),
    .i_psel       ( pctl_psel    ),
    .i_penable    ( sub_penable  ),
    .i_pwrite     ( sub_pwrite   ),
    .i_offset     ( sub_offset   ),
    .i_pwdata     ( sub_pwdata   ),
    .i_pstrb      ( sub_pstrb    ),
    .o_pready     ( pctl_pready  ),
    .o_prdata     ( pctl_prdata  ),
    .o_pslverr    ( pctl_pslverr ),
    .o_noc_clk_en ( o_noc_clk_en ),
    .o_noc_rst_n  ( o_noc_rst_n  )
  );

endmodule

// File: verification/tb_clk_gen.sv
// ============================
// Testbench clock and reset source
// 20 ns reference clock, active-low reset held for 4 cycles
// ============================

`timescale 1ns/10ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  localparam int unsigned HALF_PERIOD = 10;
  localparam int unsigned RST_CYCLES  = 4;

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD) o_clk = ~o_clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

// File: verification/syscfg_mgmt_tb.sv
// ============================
// Testbench for the system configuration block
// Random APB traffic against a register model plus directed
// error, global sync and NoC power sequencing checks
// ============================

`timescale 1ns/10ps

module syscfg_mgmt_tb
  import syscfg_pkg::*;
();

  localparam int NUM_RAND        = 200;
  localparam int NUM_XFERS       = NUM_RAND + 60;
  localparam int WATCHDOG_CYCLES = 2 * (NUM_XFERS * 2 + 200);
  localparam int SEQ_TIMEOUT     = 20;

  localparam syscfg_addr_t A_SCRATCH0 = {4'd0, MISC_SCRATCH0_OFS};
  localparam syscfg_addr_t A_SCRATCH1 = {4'd0, MISC_SCRATCH1_OFS};
  localparam syscfg_addr_t A_BOOT     = {4'd0, MISC_BOOT_MODE_OFS};
  localparam syscfg_addr_t A_SYNC     = {4'd0, MISC_GLOBAL_SYNC_OFS};
  localparam syscfg_addr_t A_CTRL     = {4'd1, PCTL_CTRL_OFS};
  localparam syscfg_addr_t A_STATUS   = {4'd1, PCTL_STATUS_OFS};

  logic         ref_clk;
  logic         rst_n;
  syscfg_addr_t paddr;
  syscfg_data_t pwdata;
  logic         pwrite;
  logic         psel;
  logic         penable;
  syscfg_strb_t pstrb;
  boot_mode_t   boot_mode;
  logic         pready;
  syscfg_data_t prdata;
  logic         pslverr;
  logic         global_sync;
  logic         noc_clk_en;
  logic         noc_rst_n;

  // Register model and bookkeeping
  syscfg_data_t scratch0_m;
  syscfg_data_t scratch1_m;
  logic         ctrl_m;
  logic         active_m;
  logic         sync_exp;
  logic [15:0]  lfsr_q = 16'd28;
  int           n_checks;
  int           n_mismatch;
  int           n_other;

  tb_clk_gen u_clk_gen (
    .o_clk   ( ref_clk ),
    .o_rst_n ( rst_n   )
  );

  syscfg_mgmt_top DUT (
    .i_ref_clk     ( ref_clk     ),
    .i_rst_n       ( rst_n       ),
    .i_paddr       ( paddr       ),
    .i_pwdata      ( pwdata      ),
    .i_pwrite      ( pwrite      ),
    .i_psel        ( psel        ),
    .i_penable     ( penable     ),
    .i_pstrb       ( pstrb       ),
    .o_pready      ( pready      ),
    .o_prdata      ( prdata      ),
    .o_pslverr     ( pslverr     ),
    .i_boot_mode   ( boot_mode   ),
    .o_global_sync ( global_sync ),
    .o_noc_clk_en  ( noc_clk_en  ),
    .o_noc_rst_n   ( noc_rst_n   )
  );

  // Galois LFSR stepped once per bit handed out
  function automatic logic [31:0] next_rand(input int nbits);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
      val    = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  function automatic syscfg_data_t strobe_merge(syscfg_data_t old_val, syscfg_data_t new_val,
                                                syscfg_strb_t strb);
    syscfg_data_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      n_mismatch++;
      $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // Expected response of one transfer with register copies updated on good writes
  task automatic predict(input logic wr, input syscfg_addr_t addr, input syscfg_data_t wdata,
                         input syscfg_strb_t strb, output logic exp_err,
                         output syscfg_data_t exp_rdata);
    exp_err   = 1'b1;
    exp_rdata = '0;
    if (addr[15:12] == 4'd0) begin
      case (addr[11:0])
        MISC_SCRATCH0_OFS: begin
          exp_err = 1'b0;
          if (wr) scratch0_m = strobe_merge(scratch0_m, wdata, strb);
          else exp_rdata = scratch0_m;
        end
        MISC_SCRATCH1_OFS: begin
          exp_err = 1'b0;
          if (wr) scratch1_m = strobe_merge(scratch1_m, wdata, strb);
          else exp_rdata = scratch1_m;
        end
        MISC_BOOT_MODE_OFS: begin
          exp_err   = wr;
          exp_rdata = wr ? '0 : {29'd0, boot_mode};
        end
        MISC_GLOBAL_SYNC_OFS: exp_err = 1'b0;
        default: exp_err = 1'b1;
      endcase
    end else if (addr[15:12] == 4'd1) begin
      case (addr[11:0])
        PCTL_CTRL_OFS: begin
          exp_err   = 1'b0;
          exp_rdata = wr ? '0 : {31'd0, ctrl_m};
          if (wr) ctrl_m = wdata[0];
        end
        PCTL_STATUS_OFS: begin
          exp_err = wr;
          if (!wr) exp_rdata = {26'd0, active_m, active_m, 2'b00, active_m ? 2'd2 : 2'd0};
        end
        default: exp_err = 1'b1;
      endcase
    end
  endtask

  // One APB transfer that returns at the falling edge after the access edge
  task automatic apb_xfer(input logic wr, input syscfg_addr_t addr, input syscfg_data_t wdata,
                          input syscfg_strb_t strb, output syscfg_data_t rdata,
                          output logic err);
    @(negedge ref_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    pstrb   = strb;
    @(negedge ref_clk);
    penable = 1'b1;
    #1;
    // Zero wait states, so pready is due in the first access cycle
    check_value("o_pready", 32'd1, 32'(pready));
    rdata = prdata;
    err   = pslverr;
    @(negedge ref_clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic checked_xfer(input logic wr, input syscfg_addr_t addr,
                              input syscfg_data_t wdata, input syscfg_strb_t strb);
    logic         exp_err;
    syscfg_data_t exp_rdata;
    logic         err;
    syscfg_data_t rdata;
    predict(wr, addr, wdata, strb, exp_err, exp_rdata);
    apb_xfer(wr, addr, wdata, strb, rdata, err);
    check_value("o_pslverr", 32'(exp_err), 32'(err));
    if (!wr) check_value("o_prdata", exp_rdata, rdata);
  endtask

  // Falling edges until the NoC clock (0) or reset (1) output reaches a level
  task automatic cycles_until(input logic on_rst, input logic level, output int cycles);
    cycles = 0;
    while ((on_rst ? noc_rst_n : noc_clk_en) !== level && cycles < SEQ_TIMEOUT) begin
      @(negedge ref_clk);
      cycles++;
    end
    if ((on_rst ? noc_rst_n : noc_clk_en) !== level) begin
      n_other++;
      $display("ERROR at %0t: %s never reached %b", $time,
               on_rst ? "o_noc_rst_n" : "o_noc_clk_en", level);
    end
  endtask

  // Sync pulse expected in the cycle after a GLOBAL_SYNC write access edge
  always @(posedge ref_clk) begin
    sync_exp <= rst_n && psel && penable && pwrite && (paddr == A_SYNC);
  end

  always @(negedge ref_clk) begin
    if (rst_n) begin
      check_value("o_global_sync", 32'(sync_exp), 32'(global_sync));
      if (noc_rst_n && !noc_clk_en) begin
        n_other++;
        $display("ERROR at %0t: NoC reset released while its clock is off", $time);
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ref_clk);
    n_other++;
    $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("Checks: %0d, mismatches: %0d, other errors: %0d", n_checks, n_mismatch, n_other);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    int           cycles;
    logic [2:0]   sel;
    logic         wr;
    syscfg_data_t wdata;
    syscfg_strb_t strb;
    syscfg_addr_t addr;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    pstrb      = '0;
    boot_mode  = 3'd5;
    scratch0_m = '0;
    scratch1_m = '0;
    ctrl_m     = 1'b0;
    active_m   = 1'b0;
    sync_exp   = 1'b0;
    n_checks   = 0;
    n_mismatch = 0;
    n_other    = 0;
    wait (rst_n === 1'b1);
    @(negedge ref_clk);

    // Reset values
    check_value("o_noc_clk_en", 32'd0, 32'(noc_clk_en));
    check_value("o_noc_rst_n", 32'd0, 32'(noc_rst_n));
    checked_xfer(1'b0, A_SCRATCH0, '0, '0);
    checked_xfer(1'b0, A_STATUS, '0, '0);
    checked_xfer(1'b0, A_BOOT, '0, '0);
    checked_xfer(1'b1, A_SYNC, 32'h1, 4'hF);

    // ============================
    // Random traffic over misc, reserved, unmapped and pctl error space
    // ============================
    for (int n = 0; n < NUM_RAND; n++) begin
      sel       = next_rand(3);
      wr        = next_rand(1);
      wdata     = next_rand(32);
      strb      = next_rand(4);
      boot_mode = next_rand(3);
      case (sel)
        3'd5:    addr = {4'd2, 12'(next_rand(4) << 2)};
        3'd6:    addr = {4'(3 + next_rand(8) % 13), 12'(next_rand(12))};
        // STATUS and the unknown offsets past it
        3'd7:    addr = {4'd1, 12'(4 + (next_rand(2) << 2))};
        default: addr = {4'd0, 12'(next_rand(3) << 2)};
      endcase
      checked_xfer(wr, addr, wdata, strb);
    end

    // Directed error cases
    checked_xfer(1'b1, {4'd2, 12'h000}, 32'hFFFF_FFFF, 4'hF);
    checked_xfer(1'b0, {4'hF, 12'h004}, '0, '0);
    checked_xfer(1'b1, {4'd0, 12'h010}, 32'h1234_5678, 4'hF);
    checked_xfer(1'b1, A_BOOT, 32'h7, 4'hF);
    checked_xfer(1'b1, A_STATUS, 32'h3F, 4'hF);
    checked_xfer(1'b0, {4'd1, 12'h008}, '0, '0);

    // ============================
    // Power-up and power-down of the NoC partition
    // ============================
    checked_xfer(1'b1, A_CTRL, 32'h1, 4'hF);
    check_value("o_noc_clk_en", 32'd1, 32'(noc_clk_en));
    check_value("o_noc_rst_n", 32'd0, 32'(noc_rst_n));
    cycles_until(1'b1, 1'b1, cycles);
    check_value("reset release delay", PCTL_SEQ_CYCLES, cycles);
    active_m = 1'b1;
    checked_xfer(1'b0, A_STATUS, '0, '0);
    checked_xfer(1'b1, A_STATUS, 32'h0, 4'hF);
    checked_xfer(1'b0, A_CTRL, '0, '0);

    checked_xfer(1'b1, A_CTRL, 32'h0, 4'hF);
    check_value("o_noc_rst_n", 32'd0, 32'(noc_rst_n));
    check_value("o_noc_clk_en", 32'd1, 32'(noc_clk_en));
    cycles_until(1'b0, 1'b0, cycles);
    check_value("clock gate delay", PCTL_SEQ_CYCLES, cycles);
    active_m = 1'b0;
    checked_xfer(1'b0, A_STATUS, '0, '0);

    // Off request while the clock is still coming up
    checked_xfer(1'b1, A_CTRL, 32'h1, 4'hF);
    checked_xfer(1'b1, A_CTRL, 32'h0, 4'hF);
    cycles_until(1'b1, 1'b1, cycles);
    check_value("o_noc_clk_en at reset release", 32'd1, 32'(noc_clk_en));
    cycles_until(1'b1, 1'b0, cycles);
    cycles_until(1'b0, 1'b0, cycles);
    check_value("o_noc_rst_n at clock gate", 32'd0, 32'(noc_rst_n));
    checked_xfer(1'b0, A_STATUS, '0, '0);

    // Registers untouched by the failed accesses
    checked_xfer(1'b0, A_SCRATCH0, '0, '0);
    checked_xfer(1'b0, A_SCRATCH1, '0, '0);
    checked_xfer(1'b0, A_CTRL, '0, '0);
    repeat (2) @(negedge ref_clk);

    $display("Checks: %0d, mismatches: %0d, other errors: %0d", n_checks, n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: syscfg_mgmt.f
common/syscfg_pkg.sv
src/syscfg_apb_decode.sv
src/syscfg_apb_router.sv
src/syscfg_misc_csr.sv
noc_pctl/noc_pctl.sv
src/syscfg_mgmt_top.sv
verification/tb_clk_gen.sv
verification/syscfg_mgmt_tb.sv
